// ==== sources.f ====
source/update_pkg.sv
source/scale_stage.sv
source/line_fifo.sv
source/update_sequencer.sv
source/glm_update.sv
test/update_checker.sv
test/tb_glm_update.sv

// ==== test/tb_glm_update.sv ====
`timescale 1ns/1ps

module tb_glm_update;
    import update_pkg::*;

    localparam int lanes = 4;
    localparam int frac_bits = 16;
    localparam int line_width = lanes * lane_width;
    localparam int n_tests = 5;
    localparam int wait_limit = 2000;

    // lines, iterations, offset, stall percent of the streams, write-almost-full bursts.
    int tab_lines [n_tests] = '{4, 6, 5, 20, 1};
    int tab_iters [n_tests] = '{1, 3, 4, 2, 3};
    int tab_offset [n_tests] = '{0, 16, 40, 64, 100};
    int tab_stall [n_tests] = '{0, 0, 40, 25, 50};
    bit tab_af [n_tests] = '{0, 0, 0, 1, 1};

    logic clk;
    logic reset;
    logic op_start;
    logic [count_width-1:0] num_lines;
    logic [count_width-1:0] num_iterations;
    logic [count_width-1:0] model_offset;
    logic busy;
    logic op_done;
    logic grad_valid;
    logic grad_ready;
    logic [lane_width-1:0] grad_data;
    logic sample_valid;
    logic sample_ready;
    logic [line_width-1:0] sample_data;
    logic model_rd_en;
    logic [count_width-1:0] model_rd_addr;
    logic [line_width-1:0] model_rd_data;
    logic model_wr_en;
    logic [count_width-1:0] model_wr_addr;
    logic [line_width-1:0] model_wr_data;
    logic model_wr_almost_full;

    int seed;
    int cycle;
    bit af_pattern;
    logic [line_width-1:0] mem [256];
    logic [line_width-1:0] rd_next;
    logic [line_width-1:0] rd_hold;
    logic [lane_width-1:0] grads [8];
    int grad_gaps [8];
    logic [line_width-1:0] samples [64];
    int sample_gaps [64];
    logic [line_width-1:0] expected [32];

    glm_update #(.lanes(lanes), .frac_bits(frac_bits), .fifo_log2_depth(4), .read_latency(2))
        DUT (.*);

    update_checker #(.line_width(line_width)) check
    (
        .clk, .reset, .op_start, .num_lines, .model_offset, .busy, .op_done,
        .grad_ready, .sample_ready, .model_rd_en, .model_wr_en, .model_wr_addr
    );

    always #50 clk = ~clk;

    // model memory with a read latency of two cycles.
    always @(posedge clk)
    begin
        rd_next = (model_rd_en === 1'b1) ? mem[model_rd_addr] : '0;
        if (model_wr_en === 1'b1)
            mem[model_wr_addr] = model_wr_data;
        cycle++;
        #5;
        model_rd_data = rd_hold;
        rd_hold = rd_next;
        model_wr_almost_full = af_pattern && (cycle % 9 < 3);   // short bursts.
    end

    function automatic logic [lane_width-1:0] scaled_lane(input logic signed [lane_width-1:0] g,
                                                          input logic signed [lane_width-1:0] s);
        logic signed [2*lane_width-1:0] p;
        p = g * s;
        return p[frac_bits +: lane_width];
    endfunction

    function automatic logic [line_width-1:0] random_line();
        logic [line_width-1:0] v;
        for (int i = 0; i < lanes; i++)
            v[i*lane_width +: lane_width] = $random(seed);
        return v;
    endfunction

    function automatic int pick_gap(input int stall);
        if ($unsigned($random(seed)) % 100 < stall)
            return 1 + $unsigned($random(seed)) % 3;
        return 0;
    endfunction

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic stop_on_failure(input string reason);
        $display("%s at %0t", reason, $time);
        $display("Errors found");
        $finish;
    endtask

    task automatic wait_ready(input bit grad);
        int n;
        n = 0;
        @(negedge clk);
        while ((grad ? grad_ready : sample_ready) !== 1'b1 && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if ((grad ? grad_ready : sample_ready) !== 1'b1)
            stop_on_failure("a stream handshake timed out");
        else
            step();                        // the transfer takes place on this edge.
    endtask

    task automatic send_gradients(input int count);
        for (int k = 0; k < count; k++)
        begin
            repeat (grad_gaps[k]) step();
            grad_valid = 1'b1;
            grad_data = grads[k];
            wait_ready(1'b1);
            grad_valid = 1'b0;
        end
    endtask

    task automatic send_samples(input int count);
        for (int j = 0; j < count; j++)
        begin
            repeat (sample_gaps[j]) step();
            sample_valid = 1'b1;
            sample_data = samples[j];
            wait_ready(1'b0);
            sample_valid = 1'b0;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (op_done !== 1'b1 && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (op_done !== 1'b1)
            stop_on_failure("op_done never came");
        else
            repeat (3) step();
    endtask

    task automatic run_test(input int t);
        int lines;
        int iters;
        int offset;
        logic [line_width-1:0] upd;
        lines = tab_lines[t];
        iters = tab_iters[t];
        offset = tab_offset[t];
        for (int it = 0; it < iters; it++)
        begin
            grads[it] = $random(seed);
            grad_gaps[it] = pick_gap(tab_stall[t]);
        end
        for (int j = 0; j < lines * iters; j++)
        begin
            samples[j] = random_line();
            sample_gaps[j] = pick_gap(tab_stall[t]);
        end
        // each line takes the updates of all iterations in order.
        for (int l = 0; l < lines; l++)
        begin
            mem[offset + l] = random_line();
            upd = mem[offset + l];
            for (int it = 0; it < iters; it++)
                for (int i = 0; i < lanes; i++)
                    upd[i*lane_width +: lane_width] = upd[i*lane_width +: lane_width] -
                        scaled_lane(grads[it], samples[it*lines + l][i*lane_width +: lane_width]);
            expected[l] = upd;
        end
        af_pattern = tab_af[t];
        op_start = 1'b1;
        num_lines = lines;
        num_iterations = iters;
        model_offset = offset;
        step();
        op_start = 1'b0;
        fork
            send_gradients(iters);
            send_samples(lines * iters);
        join
        wait_done();
        af_pattern = 1'b0;
        for (int l = 0; l < lines; l++)
            check.compare_line(offset + l, expected[l], mem[offset + l]);
        check.end_test(t, lines, iters);
    endtask

    initial
    begin
        logic [line_width-1:0] fill;
        seed = 32'hb662;
        cycle = 0;
        af_pattern = 1'b0;
        clk = 1'b0;
        reset = 1'b1;
        op_start = 1'b0;
        num_lines = '0;
        num_iterations = '0;
        model_offset = '0;
        grad_valid = 1'b0;
        grad_data = '0;
        sample_valid = 1'b0;
        sample_data = '0;
        model_rd_data = '0;
        model_wr_almost_full = 1'b0;
        rd_hold = '0;
        for (int a = 0; a < 256; a++)
        begin
            for (int i = 0; i < lanes; i++)
                fill[i*lane_width +: lane_width] = {16'(a), 16'(i)};
            mem[a] = fill;
        end
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;
        repeat (5) step();                 // the idle outputs are watched here.
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        $display("%0d tests, %0d checks, %0d errors", n_tests, check.check_count,
                 check.error_count);
        if (check.error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== test/update_checker.sv ====
`timescale 1ns/1ps

module update_checker
#(
    parameter int line_width = 128
)
(
    input  logic clk,
    input  logic reset,
    input  logic op_start,
    input  logic [update_pkg::count_width-1:0] num_lines,
    input  logic [update_pkg::count_width-1:0] model_offset,
    input  logic busy,
    input  logic op_done,
    input  logic grad_ready,
    input  logic sample_ready,
    input  logic model_rd_en,
    input  logic model_wr_en,
    input  logic [update_pkg::count_width-1:0] model_wr_addr
);
    int error_count = 0;
    int check_count = 0;
    int errors_before = 0;                 // error count when the current test began.
    int done_count = 0;
    int write_count = 0;
    int writes_at_done = 0;
    bit reset_seen = 1'b0;
    bit started = 1'b0;

    // the DUT outputs settle well before the falling edge.
    always @(negedge clk)
    begin
        if (reset)
            reset_seen = 1'b1;
        else if (reset_seen)
        begin
            if (op_start === 1'b1)
                started = 1'b1;
            else if (!started && (busy !== 1'b0 || op_done !== 1'b0 || grad_ready !== 1'b0 ||
                     sample_ready !== 1'b0 || model_rd_en !== 1'b0 || model_wr_en !== 1'b0))
            begin
                $display("outputs are not idle after reset at %0t", $time);
                error_count++;
            end
            if (model_wr_en === 1'b1)
            begin
                write_count++;
                if (int'(model_wr_addr) < int'(model_offset) ||
                    int'(model_wr_addr) >= int'(model_offset) + int'(num_lines))
                begin
                    $display("write to address %0d outside the region at %0t", model_wr_addr, $time);
                    error_count++;
                end
            end
            if (op_done === 1'b1)
            begin
                done_count++;
                writes_at_done = write_count;
                if (busy !== 1'b0 || model_wr_en !== 1'b0)
                begin
                    $display("op_done came while still busy or writing at %0t", $time);
                    error_count++;
                end
            end
        end
    end

    task automatic compare_line(input int addr, input logic [line_width-1:0] expected,
                                input logic [line_width-1:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: model line %0d is %h, expected %h", $time, addr, actual,
                     expected);
            error_count++;
        end
    endtask

    task automatic end_test(input int index, input int lines, input int iters);
        check_count++;
        if (done_count != 1)
        begin
            $display("test %0d saw op_done %0d times instead of once", index, done_count);
            error_count++;
        end
        if (writes_at_done != lines * iters || write_count != lines * iters || busy !== 1'b0)
        begin
            $display("test %0d wrote %0d lines before op_done and %0d in all, expected %0d",
                     index, writes_at_done, write_count, lines * iters);
            error_count++;
        end
        $display("test %0d: %0d lines x %0d iterations, %s", index, lines, iters,
                 (error_count == errors_before) ? "ok" : "failed");
        errors_before = error_count;
        done_count = 0;
        write_count = 0;
    endtask

endmodule

// ==== source/glm_update.sv ====
`timescale 1ns/1ps

module glm_update
#(
    parameter int lanes = 4,
    parameter int frac_bits = 16,
    parameter int fifo_log2_depth = 4,
    parameter int read_latency = 2
)
(
    input  logic clk,
    input  logic reset,

    input  logic op_start,
    input  logic [update_pkg::count_width-1:0] num_lines,
    input  logic [update_pkg::count_width-1:0] num_iterations,
    input  logic [update_pkg::count_width-1:0] model_offset,
    output logic busy,
    output logic op_done,

    input  logic grad_valid,
    output logic grad_ready,
    input  logic [update_pkg::lane_width-1:0] grad_data,

    input  logic sample_valid,
    output logic sample_ready,
    input  logic [lanes*update_pkg::lane_width-1:0] sample_data,

    output logic model_rd_en,
    output logic [update_pkg::count_width-1:0] model_rd_addr,
    input  logic [lanes*update_pkg::lane_width-1:0] model_rd_data,

    output logic model_wr_en,
    output logic [update_pkg::count_width-1:0] model_wr_addr,
    output logic [lanes*update_pkg::lane_width-1:0] model_wr_data,
    input  logic model_wr_almost_full
);
    import update_pkg::*;

    logic push;
    logic [lanes*lane_width-1:0] push_data;
    logic fifo_pop;
    logic [lanes*lane_width-1:0] fifo_head;
    logic fifo_empty;
    logic fifo_almost_full;

    scale_stage #(.lanes(lanes), .frac_bits(frac_bits)) scale
    (
        .clk, .reset, .op_start, .num_lines, .num_iterations,
        .grad_valid, .grad_ready, .grad_data,
        .sample_valid, .sample_ready, .sample_data,
        .fifo_almost_full, .push, .push_data
    );

    line_fifo #(.width(lanes*lane_width), .log2_depth(fifo_log2_depth)) scaled_lines
    (
        .clk, .reset, .push, .push_data,
        .pop(fifo_pop),
        .head(fifo_head),
        .empty(fifo_empty),
        .almost_full(fifo_almost_full)
    );

    update_sequencer #(.lanes(lanes), .read_latency(read_latency)) sequencer
    (
        .clk, .reset, .op_start, .num_lines, .num_iterations, .model_offset,
        .busy, .op_done,
        .fifo_head, .fifo_empty, .fifo_pop,
        .model_rd_en, .model_rd_addr, .model_rd_data,
        .model_wr_en, .model_wr_addr, .model_wr_data, .model_wr_almost_full
    );

endmodule

// ==== source/update_sequencer.sv ====
`timescale 1ns/1ps

module update_sequencer
#(
    parameter int lanes = 4,
    parameter int read_latency = 2
)
(
    input  logic clk,
    input  logic reset,
    input  logic op_start,
    input  logic [update_pkg::count_width-1:0] num_lines,
    input  logic [update_pkg::count_width-1:0] num_iterations,
    input  logic [update_pkg::count_width-1:0] model_offset,
    output logic busy,
    output logic op_done,

    input  logic [lanes*update_pkg::lane_width-1:0] fifo_head,
    input  logic fifo_empty,
    output logic fifo_pop,

    output logic model_rd_en,
    output logic [update_pkg::count_width-1:0] model_rd_addr,
    input  logic [lanes*update_pkg::lane_width-1:0] model_rd_data,

    output logic model_wr_en,
    output logic [update_pkg::count_width-1:0] model_wr_addr,
    output logic [lanes*update_pkg::lane_width-1:0] model_wr_data,
    input  logic model_wr_almost_full
);
    import update_pkg::*;

    update_state_t state;
    logic [count_width-1:0] lines_reg;
    logic [count_width-1:0] iters_reg;
    logic [count_width-1:0] offset_reg;
    logic [count_width-1:0] req_count;     // reads issued in this iteration.
    logic [count_width-1:0] wr_count;      // writes done in this iteration.
    logic [count_width-1:0] iter_count;
    logic rd_go;
    logic last_write;

    // popped lines wait here for the model line they belong to.
    logic dl_valid [read_latency];
    logic [lanes*lane_width-1:0] dl_line [read_latency];
    logic [count_width-1:0] dl_addr [read_latency];

    assign busy = (state != state_idle);
    assign rd_go = (state == state_main) && (req_count < lines_reg) && !fifo_empty &&
                   !model_wr_almost_full;
    assign fifo_pop = rd_go;
    assign model_rd_en = rd_go;
    assign model_rd_addr = offset_reg + req_count;
    assign last_write = model_wr_en && (wr_count == lines_reg - 1'b1);

    always_ff @(posedge clk)
    begin
        op_done <= 1'b0;
        if (model_wr_en)
            wr_count <= last_write ? '0 : wr_count + 1'b1;

        case (state)
            state_idle:
            begin
                if (op_start)
                begin
                    lines_reg <= num_lines;
                    iters_reg <= num_iterations;
                    offset_reg <= model_offset;
                    req_count <= '0;
                    wr_count <= '0;
                    iter_count <= '0;
                    state <= state_main;
                end
            end

            state_main:
            begin
                if (rd_go)
                begin
                    req_count <= req_count + 1'b1;
                    if (req_count == lines_reg - 1'b1)
                        state <= state_drain;
                end
            end

            state_drain:
            begin
                if (last_write)
                begin
                    if (iter_count == iters_reg - 1'b1)
                    begin
                        op_done <= 1'b1;
                        state <= state_idle;
                    end
                    else
                    begin
                        iter_count <= iter_count + 1'b1;
                        req_count <= '0;
                        state <= state_main;
                    end
                end
            end

            default:
                state <= state_idle;
        endcase

        if (reset)
        begin
            state <= state_idle;
            op_done <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int k = 0; k < read_latency; k++)
                dl_valid[k] <= 1'b0;
            model_wr_en <= 1'b0;
        end
        else
        begin
            dl_valid[0] <= rd_go;
            for (int k = 1; k < read_latency; k++)
                dl_valid[k] <= dl_valid[k-1];
            model_wr_en <= dl_valid[read_latency-1];
        end
    end

    always_ff @(posedge clk)
    begin
        dl_line[0] <= fifo_head;
        dl_addr[0] <= model_rd_addr;
        for (int k = 1; k < read_latency; k++)
        begin
            dl_line[k] <= dl_line[k-1];
            dl_addr[k] <= dl_addr[k-1];
        end
        model_wr_addr <= dl_addr[read_latency-1];
        for (int i = 0; i < lanes; i++)
        begin
            model_wr_data[i*lane_width +: lane_width] <=
                model_rd_data[i*lane_width +: lane_width] -
                dl_line[read_latency-1][i*lane_width +: lane_width];   // wraps modulo 2^32.
        end
    end

    // once an iteration is fully requested, no read may go out before its last write.
    a_no_read_in_drain: assert property (@(posedge clk) disable iff (reset)
        rd_go && (req_count == lines_reg - 1'b1) |=> !model_rd_en until_with last_write)
        else $error("model read issued before the previous iteration completed.");

    a_no_read_after_done: assert property (@(posedge clk) disable iff (reset)
        op_done |-> !model_rd_en until op_start)
        else $error("model read issued while idle.");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        op_done |=> !op_done)
        else $error("op_done held for more than one cycle.");

endmodule

// ==== source/line_fifo.sv ====
`timescale 1ns/1ps

module line_fifo
#(
    parameter int width = 128,
    parameter int log2_depth = 4
)
(
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  logic [width-1:0] push_data,
    input  logic pop,
    output logic [width-1:0] head,
    output logic empty,
    output logic almost_full
);
    localparam int depth = 1 << log2_depth;

    logic [width-1:0] mem [depth];
    logic [log2_depth-1:0] wr_ptr;
    logic [log2_depth-1:0] rd_ptr;
    logic [log2_depth:0] count;

    assign head = mem[rd_ptr];             // show-ahead.
    assign empty = (count == '0);
    // two free entries are kept back for lines still in the multiplier.
    assign almost_full = (count >= depth - 2);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push && !pop |-> count < depth)
        else $error("push into a full FIFO.");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty)
        else $error("pop from an empty FIFO.");

endmodule

// ==== source/scale_stage.sv ====
`timescale 1ns/1ps

module scale_stage
#(
    parameter int lanes = 4,
    parameter int frac_bits = 16
)
(
    input  logic clk,
    input  logic reset,
    input  logic op_start,
    input  logic [update_pkg::count_width-1:0] num_lines,
    input  logic [update_pkg::count_width-1:0] num_iterations,

    input  logic grad_valid,
    output logic grad_ready,
    input  logic [update_pkg::lane_width-1:0] grad_data,

    input  logic sample_valid,
    output logic sample_ready,
    input  logic [lanes*update_pkg::lane_width-1:0] sample_data,

    input  logic fifo_almost_full,
    output logic push,
    output logic [lanes*update_pkg::lane_width-1:0] push_data
);
    import update_pkg::*;

    logic active;                          // still feeding lines for this command.
    logic grad_held;
    logic signed [lane_width-1:0] grad_reg;
    logic [count_width-1:0] line_count;
    logic [count_width-1:0] iter_count;
    logic signed [lane_width-1:0] scalar;
    logic grad_fire;
    logic sample_fire;
    logic last_line;
    logic product_valid;
    logic signed [2*lane_width-1:0] product [lanes];

    // the gradient may be taken in the same cycle as the first sample line.
    assign grad_ready = active && !grad_held && (line_count == '0);
    assign grad_fire = grad_valid && grad_ready;
    assign sample_ready = active && (grad_held || grad_fire) && !fifo_almost_full;
    assign sample_fire = sample_valid && sample_ready;
    assign last_line = (line_count == num_lines - 1'b1);
    assign scalar = grad_held ? grad_reg : grad_data;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            grad_held <= 1'b0;
            line_count <= '0;
            iter_count <= '0;
        end
        else if (op_start && !active)
        begin
            active <= 1'b1;
            grad_held <= 1'b0;
            line_count <= '0;
            iter_count <= '0;
        end
        else
        begin
            if (grad_fire)
                grad_held <= 1'b1;
            if (sample_fire)
            begin
                if (last_line)
                begin
                    line_count <= '0;
                    grad_held <= 1'b0;         // the next iteration brings a new gradient.
                    iter_count <= iter_count + 1'b1;
                    if (iter_count == num_iterations - 1'b1)
                        active <= 1'b0;
                end
                else
                begin
                    line_count <= line_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (grad_fire)
            grad_reg <= grad_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            product_valid <= 1'b0;
            push <= 1'b0;
        end
        else
        begin
            product_valid <= sample_fire;
            push <= product_valid;
        end
    end

    // full-width product first, then the shift back to the fixed-point scale.
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < lanes; i++)
        begin
            product[i] <= scalar * $signed(sample_data[i*lane_width +: lane_width]);
            push_data[i*lane_width +: lane_width] <= lane_width'(product[i] >>> frac_bits);
        end
    end

    a_one_gradient_per_iteration: assert property (@(posedge clk) disable iff (reset)
        grad_fire && !(sample_fire && last_line) |=>
            !grad_fire until_with (sample_fire && last_line))
        else $error("second gradient accepted within one iteration.");

endmodule

// ==== source/update_pkg.sv ====
package update_pkg;

    // one lane of a line holds a signed fixed-point value.
    localparam int lane_width = 32;

    // line counts, iteration counts and model addresses.
    localparam int count_width = 16;

    // sequencer states.
    // state_drain holds off the next iteration until the last write of the
    // current one has left the subtract stage.
    typedef enum logic [1:0]
    {
        state_idle,
        state_main,
        state_drain
    } update_state_t;

endpackage
